//--- verilog.f
hw/axis_pkg.sv
hw/axis_fwd_reg.sv
hw/axis_skid_reg.sv
hw/axis_reg_slice.sv
hw/axis_slice_chain.sv
dv/tb_axis_slice_chain.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --timing --assert
TB_TOP    := tb_axis_slice_chain
RTL_TOP   := axis_slice_chain
FILELIST  := verilog.f
OBJ_DIR   := obj_dir

RTL_SRCS  := $(filter hw/%,$(shell cat $(FILELIST)))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --binary -Mdir $(OBJ_DIR) --top-module $(TB_TOP) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf $(OBJ_DIR)

//--- dv/tb_axis_slice_chain.sv
module tb_axis_slice_chain
    import axis_pkg::*;
();

    localparam int NUM_SLICES    = 3;
    localparam int EXP_RST_DELAY = NUM_SLICES; // one reset flop per registered slice
    localparam int THRU_BEATS    = 20;
    localparam int RAND_BEATS    = 500;

    logic       aclk;
    logic       rst_n;
    logic       rst_out_n;
    logic       s_valid;
    axis_beat_t s_beat;
    logic       s_ready;
    logic       m_valid;
    axis_beat_t m_beat;
    logic       m_ready;

    int         seed = 32'h63c8;
    axis_beat_t exp_q[$];         // accepted but not yet seen at the output
    axis_beat_t exp_beat;
    int         n_in = 0;
    int         n_out = 0;
    logic       in_fire_q = 1'b0; // input transfer on the last rising edge
    int         mon_errors = 0;
    int         seq_errors = 0;
    int         tests_run = 0;
    int         err_base = 0;

    axis_slice_chain #(
        .NUM_SLICES ( NUM_SLICES ),
        .MODE       ( SLICE_FULL )
    ) i_dut (
        .aclk      ( aclk ),
        .rst_n     ( rst_n ),
        .rst_out_n ( rst_out_n ),
        .s_valid   ( s_valid ),
        .s_beat    ( s_beat ),
        .s_ready   ( s_ready ),
        .m_valid   ( m_valid ),
        .m_beat    ( m_beat ),
        .m_ready   ( m_ready )
    );

    initial begin
        aclk = 1'b0;
        forever #2 aclk = ~aclk;
    end

    // output side first so the queue head is always the oldest beat
    always @(posedge aclk) begin
        if (rst_n) begin
            if (m_valid && m_ready) begin
                n_out++;
                if (exp_q.size() == 0) begin
                    $display("[%0t] output beat arrived with nothing expected", $time);
                    mon_errors++;
                end else begin
                    exp_beat = exp_q.pop_front();
                    a_beat_match: assert (m_beat == exp_beat) else begin
                        $display("** Error at time %0t: beat %0d is %h, expected %h",
                                 $time, n_out, m_beat, exp_beat);
                        mon_errors++;
                    end
                end
            end
            in_fire_q = s_valid && s_ready;
            if (in_fire_q) begin
                exp_q.push_back(s_beat);
                n_in++;
            end
        end
    end

    a_reset_quiet: assert property (@(posedge aclk) !rst_out_n |-> !m_valid)
        else begin
            $display("** Error at time %0t: m_valid high while the chain is in reset", $time);
            mon_errors++;
        end

    // a stalled beat stays put
    a_out_hold: assert property (@(posedge aclk) disable iff (!rst_out_n)
        $past(m_valid && !m_ready) |-> (m_valid && m_beat == $past(m_beat)))
        else begin
            $display("** Error at time %0t: stalled output beat changed or dropped", $time);
            mon_errors++;
        end

    function automatic int error_count();
        return mon_errors + seq_errors;
    endfunction

    function automatic axis_beat_t random_beat();
        axis_beat_t  b;
        logic [31:0] r;
        b.tdata[31:0]  = $random(seed);
        b.tdata[63:32] = $random(seed);
        r       = $random(seed);
        b.tkeep = r[7:0];
        b.tlast = r[8];
        b.tid   = r[12:9];
        b.tdest = r[16:13];
        b.tuser = r[24:17];
        return b;
    endfunction

    task automatic report_test(input string name);
        tests_run++;
        $display("[%0t] %s finished with %0d errors", $time, name, error_count() - err_base);
        err_base = error_count();
    endtask

    task automatic check_reset_release();
        int cyc;
        cyc   = 0;
        rst_n = 1'b1;
        while (!rst_out_n && cyc < 20) begin
            @(negedge aclk);
            cyc++;
        end
        if (!rst_out_n) begin
            $display("timeout: rst_out_n never released after rst_n went high");
            seq_errors++;
        end else begin
            assert (cyc == EXP_RST_DELAY) else begin
                $display("** Error at time %0t: rst_out_n released after %0d cycles, expected %0d",
                         $time, cyc, EXP_RST_DELAY);
                seq_errors++;
            end
        end
        assert (!m_valid) else begin
            $display("** Error at time %0t: m_valid high right after reset", $time);
            seq_errors++;
        end
    endtask

    task automatic run_throughput();
        int cyc;
        int first_out;
        int run;
        cyc       = 0;
        first_out = -1;
        run       = 0;
        m_ready   = 1'b1;
        while (!(first_out >= 0 && !m_valid) && cyc < 100) begin
            @(negedge aclk);
            if (m_valid) begin
                if (first_out < 0) begin
                    first_out = cyc;
                end
                run++;
            end
            if (cyc < THRU_BEATS) begin
                assert (s_ready) else begin
                    $display("** Error at time %0t: s_ready low at beat %0d", $time, cyc);
                    seq_errors++;
                end
                s_valid = 1'b1;
                s_beat  = random_beat();
            end else begin
                s_valid = 1'b0;
            end
            cyc++;
        end
        if (cyc >= 100) begin
            $display("timeout: output never went idle in the throughput test");
            seq_errors++;
        end else begin
            assert (first_out == NUM_SLICES && run == THRU_BEATS) else begin
                $display("** Error at time %0t: first output after %0d cycles, %0d in a row",
                         $time, first_out, run);
                seq_errors++;
            end
        end
    endtask

    task automatic run_random(input int n);
        int          sent;
        int          cyc;
        logic [31:0] r;
        sent = 0;
        cyc  = 0;
        while ((sent < n || s_valid) && cyc < 20 * n) begin
            @(negedge aclk);
            cyc++;
            r       = $random(seed);
            m_ready = r[0];
            // hold the beat until it is taken
            if (!s_valid || in_fire_q) begin
                if (sent < n && r[2:1] != 2'b00) begin
                    s_valid = 1'b1;
                    s_beat  = random_beat();
                    sent++;
                end else begin
                    s_valid = 1'b0;
                end
            end
        end
        if (cyc >= 20 * n) begin
            $display("timeout: source sent only %0d of %0d beats", sent, n);
            seq_errors++;
        end
    endtask

    task automatic drain_queue(input string what);
        int cyc;
        cyc     = 0;
        m_ready = 1'b1;
        while (exp_q.size() != 0 && cyc < 200) begin
            @(negedge aclk);
            cyc++;
        end
        if (exp_q.size() != 0) begin
            $display("timeout: %0d beats never left the chain during %s", exp_q.size(), what);
            seq_errors++;
        end
    endtask

    task automatic run_stall();
        int cyc;
        int base_in;
        int base_out;
        int accepted;
        base_in  = n_in;
        base_out = n_out;
        cyc      = 0;
        m_ready  = 1'b0;
        s_valid  = 1'b1;
        s_beat   = random_beat();
        while (s_valid && cyc < 50) begin
            @(negedge aclk);
            cyc++;
            if (in_fire_q) begin
                if (s_ready) begin
                    s_beat = random_beat();
                end else begin
                    s_valid = 1'b0; // chain is full so stop offering
                end
            end
        end
        if (s_valid) begin
            $display("timeout: s_ready never fell with m_ready held low");
            seq_errors++;
        end
        accepted = n_in - base_in;
        assert (accepted > 0 && accepted <= 2 * NUM_SLICES) else begin
            $display("** Error at time %0t: %0d beats accepted before stall, at most %0d",
                     $time, accepted, 2 * NUM_SLICES);
            seq_errors++;
        end
        drain_queue("stall drain");
        // extra beats still in flight would leave within the chain latency
        repeat (NUM_SLICES + 1) @(negedge aclk);
        assert (n_out - base_out == accepted) else begin
            $display("** Error at time %0t: drained %0d beats, %0d were accepted",
                     $time, n_out - base_out, accepted);
            seq_errors++;
        end
    endtask

    initial begin
        rst_n   = 1'b0;
        s_valid = 1'b0;
        s_beat  = '0;
        m_ready = 1'b0;
        repeat (16) @(negedge aclk);
        check_reset_release();
        report_test("reset");
        run_throughput();
        drain_queue("throughput");
        report_test("throughput");
        run_random(RAND_BEATS);
        drain_queue("random traffic");
        report_test("random traffic");
        run_stall();
        report_test("stall and drain");
        $display("tests %0d, errors %0d, beats in %0d, beats out %0d",
                 tests_run, error_count(), n_in, n_out);
        if (error_count() == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule : tb_axis_slice_chain

//--- hw/axis_slice_chain.sv
module axis_slice_chain
    import axis_pkg::*;
#(
    parameter int              NUM_SLICES = 3,
    parameter reg_slice_mode_e MODE       = SLICE_FULL
) (
    input  logic       aclk,
    input  logic       rst_n,
    output logic       rst_out_n,

    input  logic       s_valid,
    input  axis_beat_t s_beat,
    output logic       s_ready,

    output logic       m_valid,
    output axis_beat_t m_beat,
    input  logic       m_ready
);

    // index i is the input of slice i, index NUM_SLICES the chain output
    logic       [NUM_SLICES:0] valid_chain;
    logic       [NUM_SLICES:0] ready_chain;
    logic       [NUM_SLICES:0] rst_chain;
    axis_beat_t [NUM_SLICES:0] beat_chain;

    assign valid_chain[0] = s_valid;
    assign beat_chain[0]  = s_beat;
    assign s_ready        = ready_chain[0];
    assign rst_chain[0]   = rst_n;

    genvar i;
    generate
        for (i = 0; i < NUM_SLICES; i++) begin : g_slice
            axis_reg_slice #(
                .MODE ( MODE )
            ) i_slice (
                .aclk      ( aclk ),
                .rst_n     ( rst_chain[i] ),
                .rst_out_n ( rst_chain[i+1] ),   // each slice resets the next
                .s_valid   ( valid_chain[i] ),
                .s_beat    ( beat_chain[i] ),
                .s_ready   ( ready_chain[i] ),
                .m_valid   ( valid_chain[i+1] ),
                .m_beat    ( beat_chain[i+1] ),
                .m_ready   ( ready_chain[i+1] )
            );
        end
    endgenerate

    assign m_valid                 = valid_chain[NUM_SLICES];
    assign m_beat                  = beat_chain[NUM_SLICES];
    assign ready_chain[NUM_SLICES] = m_ready;
    assign rst_out_n               = rst_chain[NUM_SLICES];

endmodule : axis_slice_chain

//--- hw/axis_reg_slice.sv
module axis_reg_slice
    import axis_pkg::*;
#(
    parameter reg_slice_mode_e MODE = SLICE_FULL
) (
    input  logic       aclk,
    input  logic       rst_n,
    output logic       rst_out_n,

    input  logic       s_valid,
    input  axis_beat_t s_beat,
    output logic       s_ready,

    output logic       m_valid,
    output axis_beat_t m_beat,
    input  logic       m_ready
);

    localparam int RST_STAGES = reset_stages(MODE);

    generate
        case (MODE)
            SLICE_BYPASS: begin : g_bypass
                assign m_valid = s_valid;
                assign m_beat  = s_beat;
                assign s_ready = m_ready;
            end
            SLICE_FORWARD: begin : g_forward
                axis_fwd_reg i_fwd (
                    .aclk      ( aclk ),
                    .rst_n     ( rst_n ),
                    .in_valid  ( s_valid ),
                    .in_beat   ( s_beat ),
                    .in_ready  ( s_ready ),
                    .out_valid ( m_valid ),
                    .out_beat  ( m_beat ),
                    .out_ready ( m_ready )
                );
            end
            SLICE_REVERSE: begin : g_reverse
                axis_skid_reg i_skid (
                    .aclk      ( aclk ),
                    .rst_n     ( rst_n ),
                    .in_valid  ( s_valid ),
                    .in_beat   ( s_beat ),
                    .in_ready  ( s_ready ),
                    .out_valid ( m_valid ),
                    .out_beat  ( m_beat ),
                    .out_ready ( m_ready )
                );
            end
            default: begin : g_full
                // skid first so both s_ready and m_valid come from flops
                logic       mid_valid;
                axis_beat_t mid_beat;
                logic       mid_ready;

                axis_skid_reg i_skid (
                    .aclk      ( aclk ),
                    .rst_n     ( rst_n ),
                    .in_valid  ( s_valid ),
                    .in_beat   ( s_beat ),
                    .in_ready  ( s_ready ),
                    .out_valid ( mid_valid ),
                    .out_beat  ( mid_beat ),
                    .out_ready ( mid_ready )
                );

                axis_fwd_reg i_fwd (
                    .aclk      ( aclk ),
                    .rst_n     ( rst_n ),
                    .in_valid  ( mid_valid ),
                    .in_beat   ( mid_beat ),
                    .in_ready  ( mid_ready ),
                    .out_valid ( m_valid ),
                    .out_beat  ( m_beat ),
                    .out_ready ( m_ready )
                );
            end
        endcase

        if (RST_STAGES == 0) begin : g_rst_wire
            assign rst_out_n = rst_n;
        end else begin : g_rst_pipe
            logic [RST_STAGES-1:0] rst_q; // ones shift in after release

            always_ff @(posedge aclk or negedge rst_n) begin
                if (!rst_n) begin
                    rst_q <= '0;
                end else begin
                    rst_q <= (rst_q << 1) | RST_STAGES'(1);
                end
            end

            assign rst_out_n = rst_q[RST_STAGES-1];
        end
    endgenerate

endmodule : axis_reg_slice

//--- hw/axis_skid_reg.sv
module axis_skid_reg
    import axis_pkg::*;
(
    input  logic       aclk,
    input  logic       rst_n,

    input  logic       in_valid,
    input  axis_beat_t in_beat,
    output logic       in_ready,

    output logic       out_valid,
    output axis_beat_t out_beat,
    input  logic       out_ready
);

    logic       ready_q;    // registered in_ready
    logic       skid_full;
    logic       skid_full_d;
    axis_beat_t skid_beat;
    logic       capture;

    // beat accepted upstream but refused downstream goes to the skid
    assign capture = in_valid && ready_q && !skid_full && !out_ready;

    always_comb begin
        skid_full_d = skid_full;
        if (skid_full) begin
            if (out_ready) begin
                skid_full_d = 1'b0; // held beat drained
            end
        end else if (capture) begin
            skid_full_d = 1'b1;
        end
    end

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            skid_full <= 1'b0;
            ready_q   <= 1'b1;
        end else begin
            skid_full <= skid_full_d;
            ready_q   <= !skid_full_d;
        end
    end

    always_ff @(posedge aclk) begin
        if (capture) begin
            skid_beat <= in_beat;
        end
    end

    assign in_ready = ready_q;

    // held beat goes out ahead of anything new
    always_comb begin
        if (skid_full) begin
            out_valid = 1'b1;
            out_beat  = skid_beat;
        end else begin
            out_valid = in_valid;
            out_beat  = in_beat;
        end
    end

endmodule : axis_skid_reg

//--- hw/axis_fwd_reg.sv
module axis_fwd_reg
    import axis_pkg::*;
(
    input  logic       aclk,
    input  logic       rst_n,

    input  logic       in_valid,
    input  axis_beat_t in_beat,
    output logic       in_ready,

    output logic       out_valid,
    output axis_beat_t out_beat,
    input  logic       out_ready
);

    logic       valid_q;
    axis_beat_t beat_q;
    logic       load;

    // take a new beat when empty or when the held one leaves this cycle
    assign in_ready = out_ready || !valid_q;
    assign load     = in_valid && in_ready;

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (in_ready) begin
            valid_q <= in_valid;
        end
    end

    // payload register
    always_ff @(posedge aclk) begin
        if (load) begin
            beat_q <= in_beat;
        end
    end

    assign out_valid = valid_q;
    assign out_beat  = beat_q;

endmodule : axis_fwd_reg

//--- hw/axis_pkg.sv
package axis_pkg;

    // beat geometry
    localparam int AXIS_DATA_BYTES = 8;
    localparam int AXIS_ID_W       = 4;
    localparam int AXIS_DEST_W     = 4;
    localparam int AXIS_USER_W     = 8;

    // no tstrb since every byte is data or null
    typedef struct packed {
        logic [AXIS_DATA_BYTES*8-1:0] tdata;
        logic [AXIS_DATA_BYTES-1:0]   tkeep;
        logic                         tlast;
        logic [AXIS_ID_W-1:0]         tid;
        logic [AXIS_DEST_W-1:0]       tdest;
        logic [AXIS_USER_W-1:0]       tuser;
    } axis_beat_t;

    typedef enum logic [1:0] {
        SLICE_BYPASS  = 2'd0, // wires only
        SLICE_FORWARD = 2'd1, // valid/data registered
        SLICE_REVERSE = 2'd2, // ready registered
        SLICE_FULL    = 2'd3  // skid then forward
    } reg_slice_mode_e;

    // reset flops a slice adds on its way downstream
    function automatic int reset_stages(input reg_slice_mode_e mode);
        case (mode)
            SLICE_BYPASS: return 0;
            default:      return 1;
        endcase
    endfunction

endpackage : axis_pkg
